//--- Bender.yml
package:
  name: io_timer

export_include_dirs:
  - .

sources:
  - files:
      - timer_pkg.sv
      - bus_sync.sv
      - timer_regs.sv
      - timer_core.sv
      - io_timer.sv
  - target: test
    files:
      - tb_io_timer.sv

//--- bus_sync.sv
////////////////////////////////////////////////////////////////////////////
// bus strobe synchronizer, one read or write pulse per processor access
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "timer_defs.svh"

module bus_sync
(
  input  logic                   Clock,
  input  logic                   nReset,
  input  logic                   n_ce,
  input  logic                   n_oe,
  input  logic                   rnw,
  input  timer_pkg::timer_addr_t address,
  input  timer_pkg::timer_data_t data_in,
  output timer_pkg::bus_access_t access,
  output logic                   read_active
);

  import timer_pkg::*;

  logic        rd_level;
  logic        wr_level;
  logic [1:0]  rd_sync;
  logic [1:0]  wr_sync;
  logic        rd_prev;
  logic        wr_prev;
  logic        rd_pulse;
  logic        wr_pulse;
  logic        strobe_sync;
  timer_addr_t addr_q;
  timer_data_t data_q;

  // raw bus levels, still asynchronous to Clock
  assign rd_level = rnw & ~n_oe & ~n_ce;
  assign wr_level = ~rnw & ~n_ce;

  //////////////////////////////////////////////////////////////////////////
  // two-flop synchronizers and edge detect
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge nReset)
  begin
    if (!nReset)
    begin
      rd_sync  <= '0;
      wr_sync  <= '0;
      rd_prev  <= 1'b0;
      wr_prev  <= 1'b0;
      rd_pulse <= 1'b0;
      wr_pulse <= 1'b0;
    end
    else
    begin
      rd_sync  <= {rd_sync[0], rd_level};
      wr_sync  <= {wr_sync[0], wr_level};
      rd_prev  <= rd_sync[1];
      wr_prev  <= wr_sync[1];
      // read acts on the leading edge, 3 clocks in
      rd_pulse <= rd_sync[1] & ~rd_prev;
      // write acts once the strobe has ended
      wr_pulse <= wr_prev & ~wr_sync[1];
    end
  end

  // master holds address and data for the whole strobe
  always_ff @(posedge Clock)
  begin
    if (rd_level | wr_level)
    begin
      addr_q <= address;
      data_q <= data_in;
    end
  end

  assign access      = '{rd: rd_pulse, wr: wr_pulse, addr: addr_q, wdata: data_q};
  assign read_active = rd_sync[1];

  assign strobe_sync = rd_sync[1] | wr_sync[1];

  // read and write never act on the same cycle
  a_pulse_excl: assert property (@(posedge Clock) disable iff (!nReset)
    !(rd_pulse && wr_pulse));

  // strobes shorter than 4 clocks are outside the bus contract
  a_min_strobe: assert property (@(posedge Clock) disable iff (!nReset)
    $rose(strobe_sync) |-> strobe_sync [*4]);

endmodule

//--- io_timer.f
+incdir+.
timer_pkg.sv
bus_sync.sv
timer_regs.sv
timer_core.sv
io_timer.sv
tb_io_timer.sv

//--- io_timer.sv
////////////////////////////////////////////////////////////////////////////
// memory-mapped millisecond timer on the asynchronous processor bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "timer_defs.svh"

module io_timer
#(
  parameter int ticks_per_ms = `TIMER_TICKS_PER_MS
)
(
  input  logic                   Clock,
  input  logic                   nReset,
  input  logic                   n_ce,
  input  logic                   n_oe,
  input  logic                   rnw,
  input  timer_pkg::timer_addr_t address,
  input  timer_pkg::timer_data_t data_in,
  output timer_pkg::timer_data_t data_out,
  output logic                   data_oe,
  output logic                   n_irq
);

  import timer_pkg::*;

  bus_access_t    access;
  logic           read_active;
  counter_state_t state;
  counter_ctrl_t  ctrl;

  // bus strobes into the Clock domain
  bus_sync u_sync (
    .Clock       (Clock),
    .nReset      (nReset),
    .n_ce        (n_ce),
    .n_oe        (n_oe),
    .rnw         (rnw),
    .address     (address),
    .data_in     (data_in),
    .access      (access),
    .read_active (read_active)
  );

  timer_regs u_regs (
    .Clock       (Clock),
    .nReset      (nReset),
    .access      (access),
    .read_active (read_active),
    .state       (state),
    .ctrl        (ctrl),
    .data_out    (data_out),
    .data_oe     (data_oe),
    .n_irq       (n_irq)
  );

  timer_core #(
    .ticks_per_ms (ticks_per_ms)
  ) u_core (
    .Clock  (Clock),
    .nReset (nReset),
    .ctrl   (ctrl),
    .state  (state)
  );

endmodule

//--- tb_io_timer.sv
////////////////////////////////////////////////////////////////////////////
// io_timer testbench: bus reads and writes against a reference status model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "timer_defs.svh"

module tb_io_timer;

  import timer_pkg::*;

  // short millisecond so countdowns finish in a few hundred clocks
  localparam int ticks_per_ms = 8;
  // five tests need about 1100 clocks, longest countdown 13 ms
  localparam int max_cycles   = 4000;
  localparam int poll_limit   = 30;
  localparam int irq_limit    = 2 * 14 * ticks_per_ms;

  // status word bit positions
  localparam int status_dc = 6;

  // control words for writes to REG_STATUS
  localparam timer_data_t ctl_start    = timer_data_t'(1) << `TIMER_BIT_START;
  localparam timer_data_t ctl_run      = timer_data_t'(1) << `TIMER_BIT_RUN;
  localparam timer_data_t ctl_restart  = timer_data_t'(1) << `TIMER_BIT_RESTART;
  localparam timer_data_t ctl_periodic = timer_data_t'(1) << `TIMER_BIT_PERIODIC;
  localparam timer_data_t ctl_dcie     = timer_data_t'(1) << `TIMER_BIT_DCIE;

  logic        Clock;
  logic        nReset;
  logic        n_ce;
  logic        n_oe;
  logic        rnw;
  timer_addr_t address;
  timer_data_t data_in;
  timer_data_t data_out;
  logic        data_oe;
  logic        n_irq;

  int     cycles;
  int     checks;
  int     errors;
  int     test_errors;
  int     test_num;
  integer seed;

  io_timer #(
    .ticks_per_ms (ticks_per_ms)
  ) uut (
    .Clock    (Clock),
    .nReset   (nReset),
    .n_ce     (n_ce),
    .n_oe     (n_oe),
    .rnw      (rnw),
    .address  (address),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .n_irq    (n_irq)
  );

  // 100 ns clock
  initial
  begin
    Clock = 1'b0;
    forever #50 Clock = ~Clock;
  end

  // run limit
  initial
  begin
    cycles = 0;
    while (cycles < max_cycles)
    begin
      @(posedge Clock);
      cycles++;
    end
    $display("timeout: run did not finish within %0d clock cycles", max_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////////

  // status: irq in 15, ms flag in 7, dc flag in 6, control 5..1
  function automatic timer_data_t expected_status(timer_ctrl_t ctl, logic ms, logic dc);
    timer_data_t word;
    word     = '0;
    word[15] = (ms & ctl[`TIMER_BIT_MSIE]) | (dc & ctl[`TIMER_BIT_DCIE]);
    word[7]  = ms;
    word[6]  = dc;
    // control bits read back in place
    for (int b = `TIMER_BIT_RUN; b <= `TIMER_BIT_MSIE; b++)
      word[b] = ctl[b];
    return word;
  endfunction

  // value the down counter takes on the tick after it reaches zero
  function automatic timer_data_t reload_value(timer_ctrl_t ctl, timer_data_t count_from);
    if (!ctl[`TIMER_BIT_RESTART])
      return '0;
    return ctl[`TIMER_BIT_PERIODIC] ? count_from : '1;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // checks and reporting
  //////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(string msg);
    $display("[FAIL] %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_problem(string msg);
    $display("error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic compare_data(timer_data_t expected, timer_data_t actual, string what);
    checks++;
    if (actual !== expected)
      report_mismatch($sformatf("%s: expected %h, got %h", what, expected, actual));
  endtask

  // n_irq is sampled mid-cycle
  task automatic compare_irq(logic expected, string what);
    @(negedge Clock);
    checks++;
    if (n_irq !== expected)
      report_mismatch($sformatf("%s: n_irq expected %b, got %b", what, expected, n_irq));
  endtask

  task automatic check_bounds(timer_data_t actual, timer_data_t lo, timer_data_t hi,
                              string what);
    checks++;
    if (actual < lo || actual > hi)
      report_mismatch($sformatf("%s: %h outside %h..%h", what, actual, lo, hi));
  endtask

  task automatic end_test(string name);
    test_num++;
    $display("test %0d %s: done, %0d errors", test_num, name, errors - test_errors);
    test_errors = errors;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge Clock);
    nReset <= 1'b0;
    repeat (2) @(posedge Clock);
    nReset <= 1'b1;
  endtask

  // strobe held 6 clocks, lands 3 clocks after it ends
  task automatic bus_write(timer_addr_t addr, timer_data_t data);
    @(posedge Clock);
    n_ce    <= 1'b0;
    rnw     <= 1'b0;
    address <= addr;
    data_in <= data;
    repeat (6) @(posedge Clock);
    n_ce <= 1'b1;
    rnw  <= 1'b1;
    repeat (6) @(posedge Clock);
  endtask

  // data valid 4 clocks in, sampled in the 6th
  task automatic bus_read(timer_addr_t addr, output timer_data_t data);
    @(posedge Clock);
    n_ce    <= 1'b0;
    n_oe    <= 1'b0;
    rnw     <= 1'b1;
    address <= addr;
    repeat (5) @(posedge Clock);
    @(negedge Clock);
    data = data_out;
    checks++;
    if (data_oe !== 1'b1)
      report_mismatch("data_oe low while read data is sampled");
    @(posedge Clock);
    n_ce <= 1'b1;
    n_oe <= 1'b1;
    // let the synced read level drop
    repeat (3) @(posedge Clock);
    @(negedge Clock);
    checks++;
    if (data_oe !== 1'b0)
      report_mismatch("data_oe still high after the read ended");
    @(posedge Clock);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    timer_data_t rd;
    timer_data_t first;
    timer_data_t second;
    timer_data_t cf;
    timer_ctrl_t ctl;
    int          n;

    nReset      = 1'b0;
    n_ce        = 1'b1;
    n_oe        = 1'b1;
    rnw         = 1'b1;
    address     = '0;
    data_in     = '0;
    seed        = 32'h1e17;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    test_num    = 0;

    // status read lands before the first ms tick
    apply_reset();
    bus_read(REG_STATUS, rd);
    compare_data(expected_status('0, 1'b0, 1'b0), rd, "status after reset");
    compare_irq(1'b1, "n_irq after reset");
    // second reset so msec is read before its first tick
    apply_reset();
    bus_read(REG_MSEC, rd);
    compare_data(16'h0000, rd, "msec after reset");
    bus_read(REG_DOWN, rd);
    compare_data(16'h0000, rd, "down counter after reset");
    bus_read(REG_ID, rd);
    compare_data(`TIMER_ID, rd, "identifier");
    end_test("reset values");

    // next strobe starts 80 clocks after the first
    bus_read(REG_MSEC, first);
    repeat (69) @(posedge Clock);
    bus_read(REG_MSEC, second);
    compare_data(first + timer_data_t'(80 / ticks_per_ms), second, "msec over 80 clocks");
    bus_read(REG_STATUS, rd);
    compare_data(expected_status('0, 1'b1, 1'b0), rd, "status with ms flag");
    end_test("millisecond counter");

    // load, then run down to zero with no restart
    cf = timer_data_t'(3 + ($unsigned($random(seed)) % 10));
    bus_write(REG_MSEC, cf);
    bus_write(REG_STATUS, ctl_start);
    bus_read(REG_DOWN, rd);
    compare_data(cf, rd, "down counter after start");
    ctl = timer_ctrl_t'(ctl_run);
    bus_write(REG_STATUS, ctl_run);
    n  = 0;
    rd = 16'hffff;
    while (rd != 16'h0000 && n < poll_limit)
    begin
      bus_read(REG_DOWN, rd);
      n++;
    end
    if (rd != 16'h0000)
      report_problem("down counter never reached zero");
    bus_read(REG_DOWN, rd);
    compare_data(reload_value(ctl, cf), rd, "down counter holds at zero");
    bus_read(REG_STATUS, rd);
    compare_data(expected_status(ctl, 1'b1, 1'b1), rd, "status with dc flag");
    // a tick lands between reads, so only dc stays clear
    bus_read(REG_STATUS, rd);
    compare_data(expected_status(ctl, 1'b1, 1'b0), rd, "dc flag cleared by status read");
    end_test("one-shot countdown");

    // periodic reload from count_from
    ctl = timer_ctrl_t'(ctl_run | ctl_restart | ctl_periodic);
    bus_write(REG_STATUS, ctl_start | ctl_run | ctl_restart | ctl_periodic);
    n  = 0;
    rd = '0;
    while (!rd[status_dc] && n < poll_limit)
    begin
      bus_read(REG_STATUS, rd);
      n++;
    end
    if (!rd[status_dc])
      report_problem("dc flag never set in periodic mode");
    else
      compare_data(expected_status(ctl, 1'b1, 1'b1), rd, "status in periodic mode");
    for (n = 0; n < 4; n++)
    begin
      bus_read(REG_DOWN, rd);
      check_bounds(rd, '0, reload_value(ctl, cf), "periodic down counter");
    end
    // restart without periodic free-runs from all ones
    ctl = timer_ctrl_t'(ctl_run | ctl_restart);
    bus_write(REG_STATUS, ctl_run | ctl_restart);
    n  = 0;
    rd = '0;
    while (rd <= 16'hff00 && n < poll_limit)
    begin
      bus_read(REG_DOWN, rd);
      n++;
    end
    check_bounds(rd, 16'hff01, reload_value(ctl, cf), "free-running down counter");
    end_test("restart and periodic");

    // leftover dc flag cleared before DCIE goes on
    bus_read(REG_STATUS, rd);
    ctl = timer_ctrl_t'(ctl_run | ctl_dcie);
    bus_write(REG_STATUS, ctl_start | ctl_run | ctl_dcie);
    n = 0;
    while (n_irq === 1'b1 && n < irq_limit)
    begin
      @(negedge Clock);
      n++;
    end
    if (n_irq !== 1'b0)
      report_problem("n_irq did not go low after the countdown with DCIE set");
    bus_read(REG_STATUS, rd);
    compare_data(expected_status(ctl, 1'b1, 1'b1), rd, "status with pending irq");
    compare_irq(1'b1, "n_irq after status read");
    // same countdown, both enables clear
    ctl = timer_ctrl_t'(ctl_run);
    bus_write(REG_STATUS, ctl_start | ctl_run);
    n  = 0;
    rd = '0;
    while (!rd[status_dc] && n < poll_limit)
    begin
      bus_read(REG_STATUS, rd);
      compare_irq(1'b1, "n_irq with enables clear");
      n++;
    end
    if (!rd[status_dc])
      report_problem("dc flag never set with enables clear");
    else
      compare_data(expected_status(ctl, 1'b1, 1'b1), rd, "status with flags, no enables");
    end_test("interrupt output");

    $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- timer_core.sv
////////////////////////////////////////////////////////////////////////////
// timer core: ms prescaler, free-running ms counter and down counter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "timer_defs.svh"

module timer_core
#(
  parameter int ticks_per_ms = `TIMER_TICKS_PER_MS
)
(
  input  logic                      Clock,
  input  logic                      nReset,
  input  timer_pkg::counter_ctrl_t  ctrl,
  output timer_pkg::counter_state_t state
);

  import timer_pkg::*;

  localparam int               PRE_W    = $clog2(ticks_per_ms);
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(ticks_per_ms - 1);

  logic [PRE_W-1:0] prescale;
  logic             tick;
  logic             dc_hit;
  timer_data_t      msec;
  timer_data_t      down;

  // one tick per millisecond
  assign tick = (prescale == PRE_LAST);

  // running counter about to step 1 -> 0, a start load overrides it
  assign dc_hit = tick & ctrl.run & ~ctrl.start & (down == timer_data_t'(1));

  //////////////////////////////////////////////////////////////////////////
  // prescaler and milliseconds counter
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge nReset)
  begin
    if (!nReset)
    begin
      prescale <= '0;
      msec     <= '0;
    end
    else if (tick)
    begin
      prescale <= '0;
      // wraps at 16 bits
      msec     <= msec + 1'b1;
    end
    else
    begin
      prescale <= prescale + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // down counter
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge nReset)
  begin
    if (!nReset)
    begin
      down <= '0;
    end
    else if (ctrl.start)
    begin
      down <= ctrl.count_from;
    end
    else if (tick && ctrl.run)
    begin
      if (down != '0)
        down <= down - 1'b1;
      else if (ctrl.restart)
        // periodic reloads the preset, otherwise free-run from all ones
        down <= ctrl.periodic ? ctrl.count_from : '1;
    end
  end

  assign state = '{msec: msec, down: down, ms_event: tick, dc_event: dc_hit};

  // dc event is a millisecond tick that leaves the down counter at zero
  a_dc_on_tick: assert property (@(posedge Clock) disable iff (!nReset)
    state.dc_event |-> state.ms_event ##1 (state.down == '0));

endmodule

//--- timer_defs.svh
////////////////////////////////////////////////////////////////////////////
// io_timer build constants: bus widths, default prescale, ID word and
// the bit positions of the status/control register
////////////////////////////////////////////////////////////////////////////

`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// processor bus word and register address widths
`define TIMER_DATA_W        16
`define TIMER_ADDR_W        2

// clocks per millisecond at 24 MHz
`define TIMER_TICKS_PER_MS  24000

// constant returned from the identifier register
`define TIMER_ID            16'hA5A5

// control register bits, also mirrored into status bits 5..1
`define TIMER_BIT_START     0
`define TIMER_BIT_RUN       1
`define TIMER_BIT_RESTART   2
`define TIMER_BIT_PERIODIC  3
`define TIMER_BIT_DCIE      4
`define TIMER_BIT_MSIE      5

`endif

//--- timer_pkg.sv
////////////////////////////////////////////////////////////////////////////
// io_timer shared types: bus words, register map and block-to-block structs
////////////////////////////////////////////////////////////////////////////

`include "timer_defs.svh"

package timer_pkg;

  // plain bus word and register address
  typedef logic [`TIMER_DATA_W-1:0] timer_data_t;
  typedef logic [`TIMER_ADDR_W-1:0] timer_addr_t;

  // control field, bit 0 (START) only ever seen on the write data
  typedef logic [`TIMER_BIT_MSIE:0] timer_ctrl_t;

  // word addresses of the register map
  typedef enum logic [`TIMER_ADDR_W-1:0] {
    REG_STATUS = 2'd0,  // read status, write control
    REG_MSEC   = 2'd1,  // read milliseconds, write count_from
    REG_DOWN   = 2'd2,  // read down counter
    REG_ID     = 2'd3   // read identifier
  } reg_addr_e;

  // one clock-domain access, pulses are a single cycle wide
  typedef struct packed {
    logic        rd;
    logic        wr;
    timer_addr_t addr;
    timer_data_t wdata;
  } bus_access_t;

  // counter values and per-tick events from the timing core
  typedef struct packed {
    timer_data_t msec;
    timer_data_t down;
    logic        ms_event;
    logic        dc_event;
  } counter_state_t;

  // steering from the register block into the timing core
  typedef struct packed {
    logic        run;
    logic        restart;
    logic        periodic;
    logic        start;
    timer_data_t count_from;
  } counter_ctrl_t;

endpackage

//--- timer_regs.sv
////////////////////////////////////////////////////////////////////////////
// timer register block: control, count_from, irq flags and read-back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "timer_defs.svh"

module timer_regs
(
  input  logic                      Clock,
  input  logic                      nReset,
  input  timer_pkg::bus_access_t    access,
  input  logic                      read_active,
  input  timer_pkg::counter_state_t state,
  output timer_pkg::counter_ctrl_t  ctrl,
  output timer_pkg::timer_data_t    data_out,
  output logic                      data_oe,
  output logic                      n_irq
);

  import timer_pkg::*;

  reg_addr_e   addr;
  timer_ctrl_t control;
  timer_data_t count_from;
  logic        start_q;
  logic        ms_flag;
  logic        dc_flag;
  logic        irq;
  logic        status_rd;
  logic        ctrl_wr;
  timer_data_t status;
  timer_data_t rd_word;

  assign addr      = reg_addr_e'(access.addr);
  assign status_rd = access.rd && (addr == REG_STATUS);
  assign ctrl_wr   = access.wr && (addr == REG_STATUS);

  // request when a flag is up and its enable is set
  assign irq = (ms_flag & control[`TIMER_BIT_MSIE]) |
               (dc_flag & control[`TIMER_BIT_DCIE]);

  // status layout: irq, 7 spare, ms flag, dc flag, control 5..1, 0
  assign status = {irq, 7'b0, ms_flag, dc_flag,
                   control[`TIMER_BIT_MSIE:`TIMER_BIT_RUN], 1'b0};

  //////////////////////////////////////////////////////////////////////////
  // register writes and start pulse
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge nReset)
  begin
    if (!nReset)
    begin
      control    <= '0;
      count_from <= '0;
      start_q    <= 1'b0;
    end
    else
    begin
      // START is a one-cycle strobe, never held in control
      start_q <= ctrl_wr && access.wdata[`TIMER_BIT_START];
      if (access.wr)
      begin
        case (addr)
          REG_STATUS:
            control <= {access.wdata[`TIMER_BIT_MSIE:`TIMER_BIT_RUN], 1'b0};
          REG_MSEC:
            count_from <= access.wdata;
          // down counter and ID are read only
          default:
            ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // interrupt flags
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge nReset)
  begin
    if (!nReset)
    begin
      ms_flag <= 1'b0;
      dc_flag <= 1'b0;
      n_irq   <= 1'b1;
    end
    else
    begin
      // a new event beats a status read in the same cycle
      if (state.ms_event)
        ms_flag <= 1'b1;
      else if (status_rd)
        ms_flag <= 1'b0;
      if (state.dc_event)
        dc_flag <= 1'b1;
      else if (status_rd)
        dc_flag <= 1'b0;
      n_irq <= ~irq;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_word = status;
    case (addr)
      REG_STATUS: rd_word = status;
      REG_MSEC:   rd_word = state.msec;
      REG_DOWN:   rd_word = state.down;
      REG_ID:     rd_word = `TIMER_ID;
    endcase
  end

  always_ff @(posedge Clock or negedge nReset)
  begin
    if (!nReset)
    begin
      data_out <= '0;
      data_oe  <= 1'b0;
    end
    else
    begin
      // word sampled before any flag clear from this read
      if (access.rd)
        data_out <= rd_word;
      // drive from the load until the synced read level drops
      data_oe <= read_active & (data_oe | access.rd);
    end
  end

  assign ctrl = '{run:        control[`TIMER_BIT_RUN],
                  restart:    control[`TIMER_BIT_RESTART],
                  periodic:   control[`TIMER_BIT_PERIODIC],
                  start:      start_q,
                  count_from: count_from};

  // low irq pin needs an enabled flag or a status read or control write just before
  a_irq_source: assert property (@(posedge Clock) disable iff (!nReset)
    !n_irq |-> irq || $past(status_rd) || $past(ctrl_wr));

endmodule
